// File: include/fx3_loopback_settings.svh
`ifndef FX3_LOOPBACK_SETTINGS_SVH
`define FX3_LOOPBACK_SETTINGS_SVH

// width of one word on the slave FIFO data bus
`define FX3_DATA_W 16

// local buffer depth, one full chip burst per round
`define BUF_ADDR_W 4
`define BUF_DEPTH (1 << `BUF_ADDR_W)

// cycles from slrd_ low on the pins until the word sits in the input register
`define READ_LATENCY 2

// chip FIFO addresses on A1:A0
// consumer socket, chip to fpga
`define FX3_ADDR_OUT 2'd3
// producer socket, fpga to chip
`define FX3_ADDR_IN 2'd0
// parked address while chip select is high
`define FX3_ADDR_IDLE 2'd2

`endif

// File: verilog/fx3_loopback_pkg.sv
`include "fx3_loopback_settings.svh"

package fx3_loopback_pkg;

    // one word on the chip data bus
    typedef logic [`FX3_DATA_W-1:0] fx3_word_t;

    // master mode
    // idle waits for the read flags
    // stream_out issues the burst of reads
    // drain lets in-flight reads land in the buffer
    // stream_in writes the buffer back to the chip
    typedef enum logic [1:0] {
        MS_IDLE       = 2'd0,
        MS_STREAM_OUT = 2'd1,
        MS_DRAIN      = 2'd2,
        MS_STREAM_IN  = 2'd3
    } master_state_e;

endpackage

// File: verilog/fx3_bus_io.sv
`include "fx3_loopback_settings.svh"

module fx3_bus_io
    import fx3_loopback_pkg::*;
(
    input  logic          usb_clk,
    input  logic          reset_,
    // raw chip flags
    input  logic          flaga_i,
    input  logic          flagb_i,
    input  logic          flagc_i,
    input  logic          flagd_i,
    input  fx3_word_t     data_i,
    // per-cycle requests from the master
    input  logic          rd_req_i,
    input  logic          wr_req_i,
    input  master_state_e state_i,
    input  fx3_word_t     wr_word_i,
    // registered flags back to the master
    output logic          flaga_q_o,
    output logic          flagb_q_o,
    output logic          flagc_q_o,
    output logic          flagd_q_o,
    // captured read words into the buffer
    output logic          push_o,
    output fx3_word_t     push_word_o,
    // chip pins, all strobes active low
    output logic          slcs_o,
    output logic          sloe_o,
    output logic          slrd_o,
    output logic          slwr_o,
    output logic [1:0]    fifo_addr_o,
    output fx3_word_t     data_o,
    output logic          data_oe_o
);

    fx3_word_t                data_q;
    logic [`READ_LATENCY-1:0] rd_vld;
    logic [1:0]               fifo_addr_d;
    logic                     oe_d;

    // flags are asynchronous to our view of the burst, sample once
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            flaga_q_o <= 1'b0;
            flagb_q_o <= 1'b0;
            flagc_q_o <= 1'b0;
            flagd_q_o <= 1'b0;
        end else begin
            flaga_q_o <= flaga_i;
            flagb_q_o <= flagb_i;
            flagc_q_o <= flagc_i;
            flagd_q_o <= flagd_i;
        end
    end

    // input word register
    always_ff @(posedge usb_clk) begin
        data_q <= data_i;
    end

    assign push_word_o = data_q;

    // read valid pipeline behind the slrd_ pin
    // stage 0 follows the cycle slrd_ was low on the pins
    // last stage lines up with the matching word in data_q
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            rd_vld <= '0;
        end else begin
            rd_vld[0] <= !slrd_o;
            for (int i = 1; i < `READ_LATENCY; i++) begin
                rd_vld[i] <= rd_vld[i-1];
            end
        end
    end

    assign push_o = rd_vld[`READ_LATENCY-1];

    // address follows the mode
    // drain keeps the read socket selected while words land
    always_comb begin
        case (state_i)
            MS_STREAM_OUT, MS_DRAIN: fifo_addr_d = `FX3_ADDR_OUT;
            MS_STREAM_IN:            fifo_addr_d = `FX3_ADDR_IN;
            default:                 fifo_addr_d = `FX3_ADDR_IDLE;
        endcase
    end

    // chip drives the bus for the whole read side of the round
    assign oe_d = (state_i == MS_STREAM_OUT) || (state_i == MS_DRAIN);

    // pin registers, one cycle behind the requests
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            slcs_o      <= 1'b1;
            sloe_o      <= 1'b1;
            slrd_o      <= 1'b1;
            slwr_o      <= 1'b1;
            data_oe_o   <= 1'b0;
            fifo_addr_o <= `FX3_ADDR_IDLE;
        end else begin
            slcs_o      <= (state_i == MS_IDLE);
            sloe_o      <= !oe_d;
            slrd_o      <= !rd_req_i;
            slwr_o      <= !wr_req_i;
            data_oe_o   <= wr_req_i;
            fifo_addr_o <= fifo_addr_d;
        end
    end

    // write word goes out with its slwr_ cycle
    always_ff @(posedge usb_clk) begin
        if (wr_req_i) begin
            data_o <= wr_word_i;
        end
    end

    // bus is half duplex, reads and writes must never share a cycle
    a_no_rd_wr_overlap: assert property (@(posedge usb_clk) disable iff (!reset_)
        !(!slrd_o && !slwr_o));

endmodule

// File: verilog/buffer_fifo.sv
`include "fx3_loopback_settings.svh"

module buffer_fifo
    import fx3_loopback_pkg::*;
#(
    parameter int DATA_W = `FX3_DATA_W,
    parameter int ADDR_W = `BUF_ADDR_W
) (
    input  logic              usb_clk,
    input  logic              reset_,
    input  logic              push_i,
    input  fx3_word_t         push_data_i,
    input  logic              pop_i,
    output logic [DATA_W-1:0] pop_data_o,
    output logic              full_o,
    output logic              empty_o
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [DATA_W-1:0] mem [DEPTH];
    // extra msb on each pointer tells full from empty
    logic [ADDR_W:0]   wr_ptr;
    logic [ADDR_W:0]   rd_ptr;
    logic              do_push;
    logic              do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // same index, different lap
    assign full_o  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                     (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign empty_o = (wr_ptr == rd_ptr);

    // head word is visible before the pop, pop just advances
    assign pop_data_o = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge usb_clk) begin
        if (do_push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= push_data_i;
        end
    end

    // write side
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            wr_ptr <= '0;
        end else if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // read side
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            rd_ptr <= '0;
        end else if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // read pipeline must never outrun the buffer
    a_no_push_full: assert property (@(posedge usb_clk) disable iff (!reset_)
        push_i |-> !full_o);

    // master must not pop more words than it read
    a_no_pop_empty: assert property (@(posedge usb_clk) disable iff (!reset_)
        pop_i |-> !empty_o);

endmodule

// File: verilog/master_fsm.sv
`include "fx3_loopback_settings.svh"

module master_fsm
    import fx3_loopback_pkg::*;
(
    input  logic          usb_clk,
    input  logic          reset_,
    // registered chip flags
    input  logic          flaga_q_i,
    input  logic          flagb_q_i,
    input  logic          flagc_q_i,
    input  logic          flagd_q_i,
    // buffer holds a whole burst
    input  logic          full_i,
    output master_state_e state_o,
    output logic          rd_req_o,
    output logic          wr_req_o,
    output logic          pop_o
);

    // one extra bit so the count can reach BUF_DEPTH
    localparam int CNT_W = `BUF_ADDR_W + 1;
    localparam logic [CNT_W-1:0] BURST_LEN = CNT_W'(`BUF_DEPTH);

    master_state_e    state_q;
    master_state_e    state_d;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_d;
    logic [CNT_W-1:0] cnt_inc;
    logic             burst_done;
    logic             rd_ready;
    logic             wr_ready;

    // both flags of a socket must agree
    assign rd_ready = flagc_q_i && flagd_q_i;
    assign wr_ready = flaga_q_i && flagb_q_i;

    assign cnt_inc    = cnt_q + 1'b1;
    assign burst_done = (cnt_inc == BURST_LEN);

    // one read per stream_out cycle, no flag gating on reads
    assign rd_req_o = (state_q == MS_STREAM_OUT);

    // writes pause while the chip has no room
    assign wr_req_o = (state_q == MS_STREAM_IN) && wr_ready;

    // each write consumes the head word
    assign pop_o = wr_req_o;

    assign state_o = state_q;

    // next state and word count
    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        case (state_q)
            MS_IDLE: begin
                if (rd_ready) begin
                    state_d = MS_STREAM_OUT;
                    cnt_d   = '0;
                end
            end
            MS_STREAM_OUT: begin
                // read count is fixed, the buffer takes exactly one burst
                if (burst_done) begin
                    state_d = MS_DRAIN;
                    cnt_d   = '0;
                end else begin
                    cnt_d = cnt_inc;
                end
            end
            MS_DRAIN: begin
                // last reads still in the latency pipe
                if (full_i) begin
                    state_d = MS_STREAM_IN;
                    cnt_d   = '0;
                end
            end
            MS_STREAM_IN: begin
                if (wr_req_o) begin
                    if (burst_done) begin
                        state_d = MS_IDLE;
                        cnt_d   = '0;
                    end else begin
                        cnt_d = cnt_inc;
                    end
                end
            end
            default: begin
                state_d = MS_IDLE;
                cnt_d   = '0;
            end
        endcase
    end

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            state_q <= MS_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    // word count bounded by one burst
    a_cnt_bound: assert property (@(posedge usb_clk) disable iff (!reset_)
        cnt_q <= BURST_LEN);

    // reads only while the buffer still has room for them
    a_rd_room: assert property (@(posedge usb_clk) disable iff (!reset_)
        rd_req_o |-> !full_i);

endmodule

// File: verilog/fx3_loopback_top.sv
`include "fx3_loopback_settings.svh"

module fx3_loopback_top
    import fx3_loopback_pkg::*;
(
    input  logic       usb_clk,
    input  logic       reset_,
    // chip flags
    input  logic       flaga_i,
    input  logic       flagb_i,
    input  logic       flagc_i,
    input  logic       flagd_i,
    input  fx3_word_t  data_i,
    // slave FIFO pins
    output logic       slcs_o,
    output logic       sloe_o,
    output logic       slrd_o,
    output logic       slwr_o,
    output logic [1:0] fifo_addr_o,
    output fx3_word_t  data_o,
    output logic       data_oe_o
);

    logic          flaga_q;
    logic          flagb_q;
    logic          flagc_q;
    logic          flagd_q;
    logic          push;
    fx3_word_t     push_word;
    logic          pop;
    fx3_word_t     pop_word;
    logic          buf_full;
    logic          buf_empty;
    logic          rd_req;
    logic          wr_req;
    master_state_e state;

    // pin registers and read capture
    fx3_bus_io u_bus_io (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .flaga_i     (flaga_i),
        .flagb_i     (flagb_i),
        .flagc_i     (flagc_i),
        .flagd_i     (flagd_i),
        .data_i      (data_i),
        .rd_req_i    (rd_req),
        .wr_req_i    (wr_req),
        .state_i     (state),
        .wr_word_i   (pop_word),
        .flaga_q_o   (flaga_q),
        .flagb_q_o   (flagb_q),
        .flagc_q_o   (flagc_q),
        .flagd_q_o   (flagd_q),
        .push_o      (push),
        .push_word_o (push_word),
        .slcs_o      (slcs_o),
        .sloe_o      (sloe_o),
        .slrd_o      (slrd_o),
        .slwr_o      (slwr_o),
        .fifo_addr_o (fifo_addr_o),
        .data_o      (data_o),
        .data_oe_o   (data_oe_o)
    );

    // mode control
    master_fsm u_master_fsm (
        .usb_clk   (usb_clk),
        .reset_    (reset_),
        .flaga_q_i (flaga_q),
        .flagb_q_i (flagb_q),
        .flagc_q_i (flagc_q),
        .flagd_q_i (flagd_q),
        .full_i    (buf_full),
        .state_o   (state),
        .rd_req_o  (rd_req),
        .wr_req_o  (wr_req),
        .pop_o     (pop)
    );

    // one burst of storage between the two directions
    buffer_fifo #(
        .DATA_W (`FX3_DATA_W),
        .ADDR_W (`BUF_ADDR_W)
    ) u_buffer_fifo (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .push_i      (push),
        .push_data_i (push_word),
        .pop_i       (pop),
        .pop_data_o  (pop_word),
        .full_o      (buf_full),
        .empty_o     (buf_empty)
    );

    // buffer must be drained once a round is back in idle
    a_empty_at_idle: assert property (@(posedge usb_clk) disable iff (!reset_)
        (state == MS_STREAM_IN) ##1 (state == MS_IDLE) |-> buf_empty);

endmodule

// File: dv/fx3_model.sv
`include "fx3_loopback_settings.svh"

module fx3_model
    import fx3_loopback_pkg::*;
(
    input  logic      usb_clk,
    // pins from the DUT
    input  logic      slcs_i,
    input  logic      slrd_i,
    input  logic      slwr_i,
    input  fx3_word_t wr_data_i,
    // testbench controls
    input  logic      rd_flags_en_i,
    input  int        drop_at_i,
    input  int        drop_len_i,
    // chip side of the bus
    output logic      flaga_o,
    output logic      flagb_o,
    output logic      flagc_o,
    output logic      flagd_o,
    output fx3_word_t rd_data_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int LAT = `READ_LATENCY;

    // words still to hand out, words taken back
    fx3_word_t      rd_q[$];
    fx3_word_t      wr_q[$];
    // bit j set when slrd_ was low j cycles ago
    logic [LAT-1:0] rd_hist    = '0;
    int             rd_left    = 0;
    logic           wr_started = 1'b0;
    int             wr_cyc     = 0;
    logic           hold       = 1'b0;
    logic           in_drop    = 1'b0;
    int             late       = 0;
    int             late_max   = 0;
    logic           underrun   = 1'b0;

    initial begin
        flaga_o   = 1'b1;
        rd_data_o = '0;
    end

    // write ready never drops in this model
    assign flagb_o = 1'b1;
    // read socket has data only while words are queued
    assign flagc_o = rd_flags_en_i && (rd_left != 0);
    assign flagd_o = flagc_o;

    always @(negedge usb_clk) begin
        // read side, word appears LAT-1 cycles after the strobe cycle
        rd_hist = {rd_hist[LAT-2:0], !slrd_i};
        if (rd_hist[LAT-1]) begin
            if (rd_q.size() == 0) begin
                underrun = 1'b1;
            end else begin
                rd_data_o <= rd_q.pop_front();
                rd_left = rd_q.size();
            end
        end else begin
            rd_data_o <= '1;
        end

        // write burst cycle count, restarts with each round
        if (slcs_i) begin
            wr_started = 1'b0;
            wr_cyc     = 0;
        end else if (wr_started) begin
            wr_cyc++;
        end else if (!slwr_i) begin
            wr_started = 1'b1;
            wr_cyc     = 0;
        end
        if (!slwr_i) begin
            wr_q.push_back(wr_data_i);
        end

        // flaga is a watermark, a real chip drops it with three words of room left
        hold = (drop_len_i != 0) && wr_started && (wr_cyc >= drop_at_i) &&
               (wr_cyc < drop_at_i + drop_len_i);
        if (hold) begin
            // count writes landing after the fall
            if (!in_drop) begin
                late = 0;
            end
            if (!slwr_i) begin
                late++;
            end
            if (late > late_max) begin
                late_max = late;
            end
        end
        in_drop = hold;
        flaga_o <= !hold;
    end

    task automatic offer_word(input fx3_word_t w);
        rd_q.push_back(w);
        rd_left = rd_q.size();
    endtask

    task automatic clear_round();
        rd_q.delete();
        wr_q.delete();
        rd_left  = 0;
        late     = 0;
        late_max = 0;
        underrun = 1'b0;
    endtask

    function automatic int written_count();
        return wr_q.size();
    endfunction

    function automatic fx3_word_t written_word(input int i);
        return wr_q[i];
    endfunction

    function automatic int late_writes();
        return late_max;
    endfunction

    function automatic logic saw_underrun();
        return underrun;
    endfunction

endmodule

// File: dv/tb_fx3_loopback.sv
`include "fx3_loopback_settings.svh"

module tb_fx3_loopback
    import fx3_loopback_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          NUM_ROWS   = 3;
    localparam int          ROW_BUDGET = 4 * `BUF_DEPTH + 40;
    localparam logic [31:0] LFSR_SEED  = 32'd97302;

    // one round of the loop per row
    typedef struct packed {
        int         n_words;
        int         skip_bits;
        int         flag_delay;
        int         drop_at;
        int         drop_len;
        logic [1:0] addr_idle;
        logic [1:0] addr_rd;
        logic [1:0] addr_wr;
    } row_t;

    logic        usb_clk;
    logic        reset_;
    logic        flaga;
    logic        flagb;
    logic        flagc;
    logic        flagd;
    fx3_word_t   data_i;
    logic        slcs_o;
    logic        sloe_o;
    logic        slrd_o;
    logic        slwr_o;
    logic [1:0]  fifo_addr_o;
    fx3_word_t   data_o;
    logic        data_oe_o;
    logic        rd_flags_en;
    int          flaga_drop_at;
    int          flaga_drop_len;
    row_t        stim [NUM_ROWS];
    logic [31:0] lfsr_state;
    bit          failed;

    fx3_loopback_top UUT (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .flaga_i     (flaga),
        .flagb_i     (flagb),
        .flagc_i     (flagc),
        .flagd_i     (flagd),
        .data_i      (data_i),
        .slcs_o      (slcs_o),
        .sloe_o      (sloe_o),
        .slrd_o      (slrd_o),
        .slwr_o      (slwr_o),
        .fifo_addr_o (fifo_addr_o),
        .data_o      (data_o),
        .data_oe_o   (data_oe_o)
    );

    // chip side of the bus
    fx3_model u_chip (
        .usb_clk       (usb_clk),
        .slcs_i        (slcs_o),
        .slrd_i        (slrd_o),
        .slwr_i        (slwr_o),
        .wr_data_i     (data_o),
        .rd_flags_en_i (rd_flags_en),
        .drop_at_i     (flaga_drop_at),
        .drop_len_i    (flaga_drop_len),
        .flaga_o       (flaga),
        .flagb_o       (flagb),
        .flagc_o       (flagc),
        .flagd_o       (flagd),
        .rd_data_o     (data_i)
    );

    initial begin
        usb_clk = 1'b0;
        forever #2 usb_clk = ~usb_clk;
    end

    task automatic stop_run(input string why);
        failed = 1'b1;
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input fx3_word_t got, input fx3_word_t exp);
        if (got !== exp) begin
            $display("ERROR %s: expected 0x%h, got 0x%h", name, exp, got);
            stop_run($sformatf("%s does not match the word handed out", name));
        end
    endtask

    task automatic check_addr(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: expected 0x%h, got 0x%h", name, exp, got);
            stop_run($sformatf("%s selects the wrong socket", name));
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s: expected 0x%h, got 0x%h", name, exp, got);
            stop_run($sformatf("%s at the wrong level", name));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit of the word
    task automatic take_word(output fx3_word_t w);
        w = '0;
        for (int b = 0; b < `FX3_DATA_W; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[`FX3_DATA_W-2:0], lfsr_state[0]};
        end
    endtask

    function automatic row_t make_row(input int n_words, input int skip_bits,
                                      input int flag_delay, input int drop_at,
                                      input int drop_len);
        row_t r;
        r.n_words    = n_words;
        r.skip_bits  = skip_bits;
        r.flag_delay = flag_delay;
        r.drop_at    = drop_at;
        r.drop_len   = drop_len;
        r.addr_idle  = `FX3_ADDR_IDLE;
        r.addr_rd    = `FX3_ADDR_OUT;
        r.addr_wr    = `FX3_ADDR_IN;
        return r;
    endfunction

    task automatic build_table();
        // plain round, no back-pressure
        stim[0] = make_row(`BUF_DEPTH, 0, 3, 0, 0);
        // flaga drop in the middle of the write burst
        stim[1] = make_row(`BUF_DEPTH, 5, 6, 5, 4);
        // flaga drop on the very first write, held longer
        stim[2] = make_row(`BUF_DEPTH, 11, 1, 0, 7);
    endtask

    task automatic check_idle(input logic [1:0] addr_idle);
        check_level("slcs_o", slcs_o, 1'b1);
        check_level("sloe_o", sloe_o, 1'b1);
        check_level("slrd_o", slrd_o, 1'b1);
        check_level("slwr_o", slwr_o, 1'b1);
        check_level("data_oe_o", data_oe_o, 1'b0);
        check_addr("fifo_addr_o", fifo_addr_o, addr_idle);
    endtask

    task automatic run_row(input int idx);
        row_t      r;
        fx3_word_t exp_words[$];
        fx3_word_t w;
        int        rd_cnt;
        int        wr_cnt;
        bit        active;
        bit        done;
        r = stim[idx];
        rd_cnt = 0;
        wr_cnt = 0;
        active = 1'b0;
        done   = 1'b0;
        rd_flags_en    = 1'b0;
        flaga_drop_at  = r.drop_at;
        flaga_drop_len = r.drop_len;
        u_chip.clear_round();
        // each row starts at its own point of the sequence
        repeat (r.skip_bits) lfsr_state = lfsr_next(lfsr_state);
        for (int i = 0; i < r.n_words; i++) begin
            take_word(w);
            exp_words.push_back(w);
            u_chip.offer_word(w);
        end
        repeat (r.flag_delay) begin
            @(negedge usb_clk);
            check_idle(r.addr_idle);
        end
        rd_flags_en = 1'b1;
        // round ends when chip select returns high
        while (!done) begin
            @(negedge usb_clk);
            if (slcs_o === 1'b0) begin
                active = 1'b1;
            end
            if (!active) begin
                check_idle(r.addr_idle);
            end else if (slcs_o === 1'b1) begin
                done = 1'b1;
            end else begin
                if (slrd_o === 1'b0) begin
                    rd_cnt++;
                    if (wr_cnt != 0) begin
                        stop_run("slrd_o went low after the write-back had started");
                    end
                    check_addr("fifo_addr_o", fifo_addr_o, r.addr_rd);
                    check_level("sloe_o", sloe_o, 1'b0);
                    check_level("slwr_o", slwr_o, 1'b1);
                end
                if (slwr_o === 1'b0) begin
                    wr_cnt++;
                    check_addr("fifo_addr_o", fifo_addr_o, r.addr_wr);
                end
                check_level("data_oe_o", data_oe_o, slwr_o === 1'b0);
            end
        end
        rd_flags_en = 1'b0;
        if (rd_cnt != `BUF_DEPTH) begin
            stop_run($sformatf("row %0d saw %0d read strobes instead of %0d",
                               idx, rd_cnt, `BUF_DEPTH));
        end
        if (u_chip.written_count() != r.n_words) begin
            stop_run($sformatf("row %0d wrote back %0d words instead of %0d",
                               idx, u_chip.written_count(), r.n_words));
        end
        for (int i = 0; i < r.n_words; i++) begin
            check_word($sformatf("data_o word %0d", i), u_chip.written_word(i), exp_words[i]);
        end
        if (u_chip.late_writes() > 2) begin
            stop_run($sformatf("row %0d kept writing %0d words after flaga fell",
                               idx, u_chip.late_writes()));
        end
        if (u_chip.saw_underrun()) begin
            stop_run("the DUT read a word that the chip had not queued");
        end
        // every strobe back at rest once chip select is released
        check_idle(r.addr_idle);
    endtask

    // bound on the whole table
    initial begin
        repeat (NUM_ROWS * ROW_BUDGET) @(posedge usb_clk);
        stop_run("watchdog expired before the stimulus table finished");
    end

    initial begin
        reset_         = 1'b0;
        rd_flags_en    = 1'b0;
        flaga_drop_at  = 0;
        flaga_drop_len = 0;
        failed         = 1'b0;
        lfsr_state     = LFSR_SEED;
        build_table();
        repeat (5) @(posedge usb_clk);
        @(negedge usb_clk);
        reset_ = 1'b1;
        check_idle(`FX3_ADDR_IDLE);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        if (!failed) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            stop_run("a check failed during the run");
        end
    end

endmodule

// File: fx3_loopback_top.f
+incdir+include
verilog/fx3_loopback_pkg.sv
verilog/fx3_bus_io.sv
verilog/buffer_fifo.sv
verilog/master_fsm.sv
verilog/fx3_loopback_top.sv
dv/fx3_model.sv
dv/tb_fx3_loopback.sv

// File: Bender.yml
package:
  name: fx3_loopback

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/fx3_loopback_pkg.sv
      - verilog/fx3_bus_io.sv
      - verilog/buffer_fifo.sv
      - verilog/master_fsm.sv
      - verilog/fx3_loopback_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/fx3_model.sv
      - dv/tb_fx3_loopback.sv
